// ==== sources.f ====
+incdir+.
lsu_pkg.sv
lsu_issue.sv
lsu_req_queue.sv
lsu_scratchpad.sv
lsu_writeback.sv
lsu_top.sv
tb_lsu.sv

// ==== tb_lsu_ref.svh ====
`ifndef TB_LSU_REF_SVH
`define TB_LSU_REF_SVH

logic [31:0] lcg_state = 32'h723e;
logic [31:0] ref_mem [MEM_WORDS];   // mirror of the scratchpad, kept in issue order.

function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// preload value, different for every word.
function logic [31:0] fill_word(input int unsigned idx);
    return (idx * 32'h0101_0101) ^ 32'hc0de_0000;
endfunction

function int unsigned word_of(input logic [31:0] addr);
    return (addr >> 2) % MEM_WORDS;   // byte bits dropped, then wrapped.
endfunction

function void ref_apply(input lsu_req_t r);
    logic [31:0] a;
    for (int t = 0; t < NUM_THREADS; t++) begin   // lower lanes land first.
        a = r.base_addr[t] + r.offset;
        if (r.mask[t] && r.op == MEM_SW) begin
            ref_mem[word_of(a)] = r.store_data[t];
        end else if (r.mask[t] && r.op == MEM_SB) begin
            ref_mem[word_of(a)][8 * a[1:0] +: 8] = r.store_data[t][7:0];
        end
    end
endfunction

// expected writeback of a load, inactive lanes stay zero.
function mem_wb_t ref_load(input lsu_req_t r);
    mem_wb_t     e;
    logic [31:0] a;
    logic [31:0] w;
    e          = '0;
    e.mask     = r.mask;
    e.rd       = r.rd;
    e.warp_num = r.warp_num;
    e.pc       = r.pc;
    for (int t = 0; t < NUM_THREADS; t++) begin
        a = r.base_addr[t] + r.offset;
        w = ref_mem[word_of(a)];
        if (r.mask[t]) begin
            e.data[t] = (r.op == MEM_LBU) ? {24'b0, w[8 * a[1:0] +: 8]} : w;
        end
    end
    return e;
endfunction

`endif

// ==== tb_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
    import lsu_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int MEM_WORDS   = 256;
    localparam int ACCEPT_WAIT = 400;
    localparam int DRAIN_WAIT  = 4000;

    logic     clk;
    logic     rst;
    lsu_req_t req;
    logic     req_valid;
    logic     req_ready;
    logic     no_slot_mem;
    logic     wb_valid;
    mem_wb_t  wb;

    mem_wb_t  exp_q [$];                // expected writebacks in issue order.
    logic     rand_stall = 1'b0;
    int       seq = 0;
    int       exp_total = 0;
    int       wb_seen = 0;
    int       checks = 0;
    int       mismatches = 0;
    int       other_errors = 0;

    `include "tb_lsu_ref.svh"

    lsu_top #(.QUEUE_DEPTH(QUEUE_DEPTH), .MEM_WORDS(MEM_WORDS)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task check_value(input string what, input logic [31:0] actual, input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("FAILED at time %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task timeout_fail(input string what);
        other_errors++;
        $display("ERROR at time %0t: timed out waiting for %s", $time, what);
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
        $display("TB FAILED");
        $finish;
    endtask

    task next_cycle();
        logic [31:0] v;
        @(posedge clk);
        #1;
        if (rand_stall) begin
            v = lcg_next();
            no_slot_mem = v[30];
        end
    endtask

    function lsu_req_t make_req(input mem_op_e op, input logic [3:0] mask,
                                input logic [31:0] base, input logic [31:0] stride,
                                input logic [31:0] offset, input logic wb_flag);
        lsu_req_t r;
        r          = '0;
        r.mask     = mask;
        r.op       = op;
        r.rd       = seq[4:0];
        r.warp_num = seq[NW_BITS-1:0];
        r.wb       = wb_flag;
        r.pc       = 32'h100 + 4 * seq;
        r.offset   = offset;
        for (int t = 0; t < NUM_THREADS; t++) begin
            r.base_addr[t]  = base + stride * t;
            r.store_data[t] = lcg_next();
        end
        seq++;
        return r;
    endfunction

    // holds req_valid until taken or until limit cycles pass.
    task send_req(input lsu_req_t r, input int limit, output bit ok);
        int waited;
        waited    = 0;
        ok        = 1'b0;
        req       = r;
        req_valid = 1'b1;
        while (!req_ready && waited < limit) begin
            next_cycle();
            waited++;
        end
        if (req_ready) begin
            next_cycle();
            ok = 1'b1;
            ref_apply(r);
            if (r.mask != '0 && r.wb && (r.op == MEM_LW || r.op == MEM_LBU)) begin
                exp_q.push_back(ref_load(r));
                exp_total++;
            end
        end
        req_valid = 1'b0;
    endtask

    task issue(input lsu_req_t r);
        bit ok;
        send_req(r, ACCEPT_WAIT, ok);
        if (!ok) begin
            timeout_fail("request accept");
        end
    endtask

    task wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            if (waited >= DRAIN_WAIT) begin
                timeout_fail("writebacks to drain");
            end
            next_cycle();
            waited++;
        end
    endtask

    // a writeback is consumed on the next edge, so it is checked here.
    initial begin : compare
        mem_wb_t e;
        forever begin
            @(negedge clk);
            if (!rst && wb_valid && !no_slot_mem) begin
                wb_seen++;
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("ERROR at time %0t: writeback arrived with none expected", $time);
                end else begin
                    e = exp_q.pop_front();
                    check_value("mask", wb.mask, e.mask);
                    check_value("rd", wb.rd, e.rd);
                    check_value("warp", wb.warp_num, e.warp_num);
                    check_value("pc", wb.pc, e.pc);
                    for (int t = 0; t < NUM_THREADS; t++) begin
                        check_value($sformatf("data lane %0d", t), wb.data[t], e.data[t]);
                    end
                end
            end
        end
    end

    initial begin
        lsu_req_t    r;
        logic [31:0] v;
        bit          ok;
        bit          saw_full;
        req         = '0;
        req_valid   = 1'b0;
        no_slot_mem = 1'b0;
        rst         = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("req_ready after reset", req_ready, 1'b1);
        check_value("wb_valid after reset", wb_valid, 1'b0);

        // preload every word so later loads see known data.
        for (int k = 0; k < MEM_WORDS / NUM_THREADS; k++) begin
            r = make_req(MEM_SW, 4'hf, 16 * k, 4, 0, 1'b0);
            for (int t = 0; t < NUM_THREADS; t++) begin
                r.store_data[t] = fill_word(4 * k + t);
            end
            issue(r);
        end

        issue(make_req(MEM_SW, 4'hf, 32'h3f0, 4, 32'h20, 1'b1));   // wraps to words 4..7.
        issue(make_req(MEM_LW, 4'hf, 32'h10, 5, 0, 1'b1));
        issue(make_req(MEM_LW, 4'hf, 32'h1_0000, 4, 32'h10, 1'b1));
        issue(make_req(MEM_SB, 4'hf, 32'h100, 5, 0, 1'b1));
        issue(make_req(MEM_SB, 4'hf, 32'h200, 1, 0, 1'b0));        // four bytes of one word.
        issue(make_req(MEM_LW, 4'hf, 32'h100, 4, 0, 1'b1));
        issue(make_req(MEM_LBU, 4'hf, 32'h100, 5, 0, 1'b1));
        issue(make_req(MEM_LW, 4'h1, 32'h200, 0, 0, 1'b1));
        issue(make_req(MEM_LBU, 4'hf, 32'h1fc, 1, 4, 1'b1));
        wait_drain();

        // partial masks, and requests that give no writeback.
        issue(make_req(MEM_SW, 4'b0101, 32'h80, 4, 0, 1'b1));
        issue(make_req(MEM_LW, 4'b1111, 32'h80, 4, 0, 1'b1));
        issue(make_req(MEM_LW, 4'b1010, 32'h80, 4, 0, 1'b1));
        issue(make_req(MEM_LW, 4'b1111, 32'h80, 4, 0, 1'b0));
        issue(make_req(MEM_LW, 4'b0000, 32'h80, 4, 0, 1'b1));
        issue(make_req(MEM_LBU, 4'b0110, 32'h101, 1, 0, 1'b1));
        wait_drain();

        no_slot_mem = 1'b1;
        saw_full    = 1'b0;
        for (int n = 0; n < 12 && !saw_full; n++) begin
            send_req(make_req(MEM_LW, 4'hf, 32'h40 * n, 4, 0, 1'b1), 20, ok);
            saw_full = !ok;
        end
        check_value("req_ready closed under stall", saw_full, 1'b1);
        check_value("wb_valid held under stall", wb_valid, 1'b1);
        no_slot_mem = 1'b0;
        wait_drain();

        rand_stall = 1'b1;
        for (int n = 0; n < 48; n++) begin
            v = lcg_next();
            r = make_req(mem_op_e'(v[31:30]), v[27:24], lcg_next() >> 16,
                         v[21:14], v[13:6], v[23] | v[22]);
            issue(r);
        end
        wait_drain();
        rand_stall  = 1'b0;
        no_slot_mem = 1'b0;
        for (int n = 0; n < 20; n++) begin
            next_cycle();
        end
        check_value("writebacks consumed", wb_seen, exp_total);

        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MEM_WORDS   = 256
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire lsu_pkg::lsu_req_t req,
    input  wire logic              req_valid,
    output logic                   req_ready,
    input  wire logic              no_slot_mem,
    output logic                   wb_valid,
    output lsu_pkg::mem_wb_t       wb
);
    import lsu_pkg::*;

    logic        push;
    mem_req_t    push_data;
    logic        credit_return;
    logic        head_valid;
    mem_req_t    head;
    logic        pop;
    logic        rsp_valid;
    thread_rsp_t rsp;
    logic        rsp_ready;

    lsu_issue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_issue (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .push          (push),
        .push_data     (push_data),
        .credit_return (credit_return)
    );

    lsu_req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk           (clk),
        .rst           (rst),
        .push          (push),
        .push_data     (push_data),
        .head_valid    (head_valid),
        .head          (head),
        .pop           (pop),
        .credit_return (credit_return)
    );

    lsu_scratchpad #(
        .MEM_WORDS (MEM_WORDS)
    ) u_scratchpad (
        .clk        (clk),
        .rst        (rst),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_ready  (rsp_ready)
    );

    lsu_writeback u_writeback (
        .clk         (clk),
        .rst         (rst),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .rsp_ready   (rsp_ready),
        .no_slot_mem (no_slot_mem),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

endmodule

`default_nettype wire

// ==== lsu_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_writeback (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 rsp_valid,
    input  wire lsu_pkg::thread_rsp_t rsp,
    output logic                      rsp_ready,
    input  wire logic                 no_slot_mem,
    output logic                      wb_valid,
    output lsu_pkg::mem_wb_t          wb
);
    import lsu_pkg::*;

    logic [NUM_THREADS-1:0]       acc_mask;
    logic [NUM_THREADS-1:0][31:0] acc_data;
    logic [NUM_THREADS-1:0]       next_mask;
    logic [NUM_THREADS-1:0][31:0] next_data;
    logic                         take;

    assign rsp_ready = !wb_valid;   // hold the scratchpad while a writeback waits.
    assign take      = rsp_valid && rsp_ready;

    always_comb begin
        next_mask = acc_mask;
        if (rsp.is_load) begin
            next_mask[rsp.tid] = 1'b1;
        end
        for (int t = 0; t < NUM_THREADS; t++) begin
            next_data[t] = acc_mask[t] ? acc_data[t] : '0;
        end
        next_data[rsp.tid] = rsp.data;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            acc_data <= next_data;
        end
        if (take && rsp.last) begin
            wb.mask     <= next_mask;
            wb.rd       <= rsp.rd;
            wb.warp_num <= rsp.warp_num;
            wb.pc       <= rsp.pc;
            wb.data     <= next_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_mask <= '0;
            wb_valid <= 1'b0;
        end else begin
            if (take) begin
                acc_mask <= rsp.last ? '0 : next_mask; // stores just clear on last.
            end
            if (take && rsp.last && rsp.is_load && rsp.wb) begin
                wb_valid <= 1'b1;
            end else if (wb_valid && !no_slot_mem) begin
                wb_valid <= 1'b0;
            end
        end
    end

    a_wb_hold: assert property (
        @(posedge clk) disable iff (rst)
        wb_valid && no_slot_mem |=> wb_valid && $stable(wb)
    ) else $error("lsu_writeback: writeback changed under stall");

endmodule

`default_nettype wire

// ==== lsu_scratchpad.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_scratchpad #(
    parameter int MEM_WORDS = 256
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              head_valid,
    input  wire lsu_pkg::mem_req_t head,
    output logic                   pop,
    output logic                   rsp_valid,
    output lsu_pkg::thread_rsp_t   rsp,
    input  wire logic              rsp_ready
);
    import lsu_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    typedef enum logic {
        IDLE,
        SERVE
    } state_e;

    logic [31:0]            mem [MEM_WORDS];
    state_e                 state;
    mem_req_t               cur;
    logic [NUM_THREADS-1:0] remain;
    logic [NUM_THREADS-1:0] remain_next;
    logic [TID_BITS-1:0]    sel;
    logic [31:0]            addr_sel;
    logic [AW-1:0]          widx;
    logic [1:0]             bsel;
    logic [31:0]            rdata;
    logic [31:0]            wdata;
    logic [31:0]            ld_data;
    logic                   is_load;
    logic                   fire;

    // lowest active thread goes first.
    always_comb begin
        sel = '0;
        for (int t = NUM_THREADS - 1; t >= 0; t--) begin
            if (remain[t]) begin
                sel = TID_BITS'(t);
            end
        end
    end

    assign remain_next = remain & ~(NUM_THREADS'(1) << sel);
    assign addr_sel    = cur.addr[sel];
    assign widx        = addr_sel[AW+1:2];            // size is a power of two, so this wraps.
    assign bsel        = addr_sel[1:0];
    assign rdata       = mem[widx];
    assign is_load     = (cur.op == MEM_LW) || (cur.op == MEM_LBU);

    always_comb begin
        wdata   = rdata;
        ld_data = rdata;
        case (cur.op)
            MEM_SW:  wdata = cur.store_data[sel];
            MEM_SB:  wdata[8*bsel +: 8] = cur.store_data[sel][7:0]; // byte merge.
            MEM_LBU: ld_data = {24'b0, rdata[8*bsel +: 8]};
            default: ld_data = rdata;
        endcase
    end

    assign pop       = (state == IDLE) && head_valid;
    assign rsp_valid = (state == SERVE);
    assign fire      = rsp_valid && rsp_ready;

    always_comb begin
        rsp.tid      = sel;
        rsp.last     = (remain_next == '0);
        rsp.data     = is_load ? ld_data : '0;
        rsp.rd       = cur.rd;
        rsp.warp_num = cur.warp_num;
        rsp.wb       = cur.wb;
        rsp.pc       = cur.pc;
        rsp.is_load  = is_load;
    end

    always_ff @(posedge clk) begin
        if (fire && !is_load) begin
            mem[widx] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= head;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            remain <= '0;
        end else if (pop) begin
            state  <= SERVE;
            remain <= head.mask;
        end else if (fire) begin
            remain <= remain_next;
            if (remain_next == '0) begin
                state <= IDLE;
            end
        end
    end

    // issue drops empty masks, so a served request always has work left.
    a_remain_nonempty: assert property (
        @(posedge clk) disable iff (rst) state == SERVE |-> remain != '0
    ) else $error("lsu_scratchpad: empty thread mask in SERVE");

endmodule

`default_nettype wire

// ==== lsu_req_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              push,
    input  wire lsu_pkg::mem_req_t push_data,
    output logic                   head_valid,
    output lsu_pkg::mem_req_t      head,
    input  wire logic              pop,
    output logic                   credit_return
);
    import lsu_pkg::*;

    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    mem_req_t       entries [QUEUE_DEPTH];
    logic [PW-1:0]  rd_ptr;
    logic [PW-1:0]  wr_ptr;
    logic [CW-1:0]  count;

    assign head_valid = (count != '0);
    assign head       = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr        <= '0;
            wr_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count         <= count + CW'(push) - CW'(pop);
            credit_return <= pop;                   // one credit per pop, a cycle later.
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst) push |-> count != CW'(QUEUE_DEPTH)
    ) else $error("lsu_req_queue: push while full");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst) pop |-> count != '0
    ) else $error("lsu_req_queue: pop while empty");

endmodule

`default_nettype wire

// ==== lsu_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_issue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire lsu_pkg::lsu_req_t req,
    input  wire logic              req_valid,
    output logic                   req_ready,
    output logic                   push,
    output lsu_pkg::mem_req_t      push_data,
    input  wire logic              credit_return
);
    import lsu_pkg::*;

    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    mem_req_t        req_d;
    mem_req_t        req_q;
    logic            req_q_valid;
    logic [CW-1:0]   credits;
    logic            take;

    // per-thread address generation.
    always_comb begin
        req_d.mask       = req.mask;
        req_d.op         = req.op;
        req_d.rd         = req.rd;
        req_d.warp_num   = req.warp_num;
        req_d.wb         = req.wb;
        req_d.pc         = req.pc;
        req_d.store_data = req.store_data;
        for (int t = 0; t < NUM_THREADS; t++) begin
            req_d.addr[t] = req.base_addr[t] + req.offset;
        end
    end

    assign push      = req_q_valid && (credits != '0); // only with a credit in hand.
    assign req_ready = !req_q_valid || push;
    assign take      = req_valid && req_ready;
    assign push_data = req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q_valid <= 1'b0;
        end else if (take) begin
            req_q_valid <= |req.mask;                // empty mask is dropped here.
        end else if (push) begin
            req_q_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_q <= req_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CW'(QUEUE_DEPTH);
        end else begin
            credits <= credits + CW'(credit_return) - CW'(push);
        end
    end

    // queue must never hand back more credits than it has slots.
    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst) credits <= CW'(QUEUE_DEPTH)
    ) else $error("lsu_issue: credit count above queue depth");

endmodule

`default_nettype wire

// ==== lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int NUM_THREADS = 4;                   // threads per warp.
    localparam int NUM_WARPS   = 4;
    localparam int NW_BITS     = $clog2(NUM_WARPS);
    localparam int TID_BITS    = $clog2(NUM_THREADS); // thread index width.

    typedef enum logic [2:0] {
        MEM_LW  = 3'd0,
        MEM_LBU = 3'd1,
        MEM_SW  = 3'd2,
        MEM_SB  = 3'd3
    } mem_op_e;

    // request as it arrives from the issue side.
    typedef struct packed {
        logic [NUM_THREADS-1:0]       mask;
        mem_op_e                      op;
        logic [4:0]                   rd;
        logic [NW_BITS-1:0]           warp_num;
        logic                         wb;
        logic [31:0]                  pc;
        logic [NUM_THREADS-1:0][31:0] base_addr;
        logic [NUM_THREADS-1:0][31:0] store_data;
        logic [31:0]                  offset;       // shared by all threads.
    } lsu_req_t;

    // queued request, addresses already formed.
    typedef struct packed {
        logic [NUM_THREADS-1:0]       mask;
        mem_op_e                      op;
        logic [4:0]                   rd;
        logic [NW_BITS-1:0]           warp_num;
        logic                         wb;
        logic [31:0]                  pc;
        logic [NUM_THREADS-1:0][31:0] addr;
        logic [NUM_THREADS-1:0][31:0] store_data;
    } mem_req_t;

    // one serviced thread.
    typedef struct packed {
        logic [TID_BITS-1:0] tid;
        logic                last;                 // final thread of the request.
        logic [31:0]         data;
        logic [4:0]          rd;
        logic [NW_BITS-1:0]  warp_num;
        logic                wb;
        logic [31:0]         pc;
        logic                is_load;
    } thread_rsp_t;

    typedef struct packed {
        logic [NUM_THREADS-1:0]       mask;
        logic [4:0]                   rd;
        logic [NW_BITS-1:0]           warp_num;
        logic [31:0]                  pc;
        logic [NUM_THREADS-1:0][31:0] data;         // zero in inactive lanes.
    } mem_wb_t;

endpackage

`default_nettype wire
